// File: vlog.f
logic/zx_mem_pkg.sv
logic/io_port_decode.sv
logic/paging_regs.sv
logic/ram_address_map.sv
logic/ula_sound_out.sv
logic/zx_mem_top.sv
tb/zx_mem_checker.sv
tb/zx_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the paging core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary -f vlog.f --top-module zx_mem_tb -o zx_mem_sim

./obj_dir/zx_mem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: tb/zx_mem_tb.sv
/*
 * Testbench top for the Spectrum paging core.
 * Builds a table of bus operations, applies it in a loop on the falling
 * clock edge and lets the checker compare the DUT outputs after each one.
 * A watchdog bounds the run from the table length.
 */
module zx_mem_tb;

	localparam int MAX_ENTRIES = 64;
	localparam int CLK_PERIOD  = 100;
	localparam int RESET_CYCLES = 10;

	// Entry kinds
	localparam int K_READ  = 0;
	localparam int K_WRITE = 1;
	localparam int K_IO    = 2;
	localparam int K_RESET = 3;

	logic        clk_sys;
	logic        reset;
	logic [15:0] addr;
	logic [7:0]  data_out;
	logic        n_mreq;
	logic        n_iorq;
	logic        n_rd;
	logic        n_wr;
	logic        n_m1;
	logic [2:0]  model;
	logic [11:0] psg_left;
	logic [11:0] psg_right;
	logic [24:0] ram_addr;
	logic        ram_rd;
	logic        ram_we;
	logic [2:0]  border_color;
	logic        screen_page;
	logic [15:0] audio_left;
	logic [15:0] audio_right;

	logic         check_strobe;
	logic [159:0] cur_name;
	logic         table_ready;

	// ==============================
	// Stimulus table
	// ==============================

	logic [159:0] t_name [MAX_ENTRIES];
	int           t_kind [MAX_ENTRIES];
	logic [15:0]  t_addr [MAX_ENTRIES];
	logic [7:0]   t_data [MAX_ENTRIES];
	logic [2:0]   t_model [MAX_ENTRIES];
	logic [11:0]  t_psgl [MAX_ENTRIES];
	logic [11:0]  t_psgr [MAX_ENTRIES];
	int           n_entries;
	int           n_resets;

	zx_mem_top dut_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.data_out     (data_out),
		.n_mreq       (n_mreq),
		.n_iorq       (n_iorq),
		.n_rd         (n_rd),
		.n_wr         (n_wr),
		.n_m1         (n_m1),
		.model        (model),
		.psg_left     (psg_left),
		.psg_right    (psg_right),
		.ram_addr     (ram_addr),
		.ram_rd       (ram_rd),
		.ram_we       (ram_we),
		.border_color (border_color),
		.screen_page  (screen_page),
		.audio_left   (audio_left),
		.audio_right  (audio_right)
	);

	zx_mem_checker checker_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.check_strobe (check_strobe),
		.test_name    (cur_name),
		.addr         (addr),
		.data_out     (data_out),
		.n_mreq       (n_mreq),
		.n_iorq       (n_iorq),
		.n_rd         (n_rd),
		.n_wr         (n_wr),
		.n_m1         (n_m1),
		.model        (model),
		.psg_left     (psg_left),
		.psg_right    (psg_right),
		.ram_addr     (ram_addr),
		.ram_rd       (ram_rd),
		.ram_we       (ram_we),
		.border_color (border_color),
		.screen_page  (screen_page),
		.audio_left   (audio_left),
		.audio_right  (audio_right)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_sys = ~clk_sys;
		end
	end

	task automatic add_entry(input logic [159:0] name, input int kind,
			input logic [15:0] a, input logic [7:0] d, input logic [2:0] m,
			input logic [11:0] pl, input logic [11:0] pr);
		t_name[n_entries]  = name;
		t_kind[n_entries]  = kind;
		t_addr[n_entries]  = a;
		t_data[n_entries]  = d;
		t_model[n_entries] = m;
		t_psgl[n_entries]  = pl;
		t_psgr[n_entries]  = pr;
		n_entries = n_entries + 1;
		if (kind == K_RESET) begin
			n_resets = n_resets + 1;
		end
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		logic [31:0] rnd2;
		n_entries = 0;
		n_resets  = 0;
		// After reset on the 128
		add_entry("reset_128", K_RESET, 16'h0000, 8'h00, 3'd0, 12'h0, 12'h0);
		add_entry("rd_slot0_rom", K_READ, 16'h0123, 8'h00, 3'd0, 12'h0, 12'h0);
		add_entry("rd_slot1", K_READ, 16'h4567, 8'h00, 3'd0, 12'h0, 12'h0);
		add_entry("rd_slot2", K_READ, 16'h89ab, 8'h00, 3'd0, 12'h0, 12'h0);
		add_entry("rd_slot3", K_READ, 16'hcdef, 8'h00, 3'd0, 12'h0, 12'h0);
		add_entry("wr_slot0_rom", K_WRITE, 16'h2001, 8'h00, 3'd0, 12'h0, 12'h0);
		// Random bank and ROM bits on 7FFD, screen bit set
		for (int i = 0; i < 3; i++) begin
			rnd = $urandom();
			add_entry("io_7ffd_rand", K_IO, 16'h7ffd,
				{3'b000, rnd[4], 1'b1, rnd[2:0]}, 3'd0, 12'h0, 12'h0);
			add_entry("rd_slot3_bank", K_READ, 16'hc3a5, 8'h00, 3'd0, 12'h0, 12'h0);
			add_entry("rd_slot0_page", K_READ, 16'h1234, 8'h00, 3'd0, 12'h0, 12'h0);
		end
		// The locked write flips every paging bit it would change
		rnd = $urandom();
		add_entry("io_7ffd_lock", K_IO, 16'h7ffd, {3'b001, rnd[4:0]}, 3'd0, 12'h0, 12'h0);
		add_entry("io_7ffd_locked", K_IO, 16'h7ffd, {3'b000, ~rnd[4:0]}, 3'd0,
			12'h0, 12'h0);
		add_entry("rd_slot3_locked", K_READ, 16'hfff0, 8'h00, 3'd0, 12'h0, 12'h0);
		// +3 special all-RAM modes
		add_entry("reset_plus3", K_RESET, 16'h0000, 8'h00, 3'd4, 12'h0, 12'h0);
		for (int c = 0; c < 4; c++) begin
			add_entry("io_1ffd_special", K_IO, 16'h1ffd, {5'b00000, 2'(c), 1'b1}, 3'd4,
				12'h0, 12'h0);
			add_entry("sp_rd_slot0", K_READ, 16'h0042, 8'h00, 3'd4, 12'h0, 12'h0);
			add_entry("sp_rd_slot1", K_READ, 16'h7abc, 8'h00, 3'd4, 12'h0, 12'h0);
			add_entry("sp_rd_slot2", K_READ, 16'h8001, 8'h00, 3'd4, 12'h0, 12'h0);
			add_entry("sp_rd_slot3", K_READ, 16'hd00d, 8'h00, 3'd4, 12'h0, 12'h0);
			add_entry("sp_wr_slot0", K_WRITE, 16'h3fff, 8'h00, 3'd4, 12'h0, 12'h0);
		end
		// 48 ignores paging
		add_entry("reset_48", K_RESET, 16'h0000, 8'h00, 3'd3, 12'h0, 12'h0);
		add_entry("io_7ffd_48", K_IO, 16'h7ffd, 8'h17, 3'd3, 12'h0, 12'h0);
		add_entry("rd48_slot0", K_READ, 16'h0777, 8'h00, 3'd3, 12'h0, 12'h0);
		add_entry("wr48_slot0", K_WRITE, 16'h0778, 8'h00, 3'd3, 12'h0, 12'h0);
		add_entry("rd48_slot3", K_READ, 16'hc000, 8'h00, 3'd3, 12'h0, 12'h0);
		// FE writes with random PSG samples, negative when the top bit is set
		for (int i = 0; i < 6; i++) begin
			rnd  = $urandom();
			rnd2 = $urandom();
			add_entry("io_fe_audio", K_IO, {rnd2[31:24], 8'hfe}, rnd[7:0], 3'd3,
				rnd2[11:0], rnd[27:16]);
		end
	endtask

	task automatic drive_idle();
		n_mreq = 1'b1;
		n_iorq = 1'b1;
		n_rd   = 1'b1;
		n_wr   = 1'b1;
		n_m1   = 1'b1;
	endtask

	// ==============================
	// Main sequence
	// ==============================

	initial begin
		void'($urandom(9636));
		table_ready  = 1'b0;
		check_strobe = 1'b0;
		cur_name     = '0;
		reset        = 1'b1;
		model        = 3'd0;
		addr         = 16'h0000;
		data_out     = 8'h00;
		psg_left     = 12'h000;
		psg_right    = 12'h000;
		drive_idle();
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		for (int i = 0; i < n_entries; i++) begin
			@(negedge clk_sys);
			cur_name  = t_name[i];
			addr      = t_addr[i];
			data_out  = t_data[i];
			psg_left  = t_psgl[i];
			psg_right = t_psgr[i];
			if (t_kind[i] == K_RESET) begin
				// Model only changes under reset
				model = t_model[i];
				reset = 1'b1;
				repeat (RESET_CYCLES) @(posedge clk_sys);
				@(negedge clk_sys);
				reset = 1'b0;
			end else begin
				if (t_kind[i] == K_READ) begin
					n_mreq = 1'b0;
					n_rd   = 1'b0;
				end else if (t_kind[i] == K_WRITE) begin
					n_mreq = 1'b0;
					n_wr   = 1'b0;
				end else begin
					n_iorq = 1'b0;
					n_wr   = 1'b0;
				end
				repeat (4) @(posedge clk_sys);
				#(CLK_PERIOD / 4) check_strobe = 1'b1;
				@(negedge clk_sys);
				check_strobe = 1'b0;
				drive_idle();
				@(posedge clk_sys);
			end
		end
		@(negedge clk_sys);
		$display("Tests: %0d  errors: %0d", checker_i.test_count, checker_i.error_count);
		if (checker_i.error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Watchdog from the table length
	initial begin
		int limit;
		wait (table_ready);
		limit = (n_entries * 6 + (n_resets + 1) * RESET_CYCLES + 10) * CLK_PERIOD;
		#(limit);
		$display("Timeout: the test table did not finish in time");
		$display("Done: errors found");
		$finish;
	end

endmodule

// File: tb/zx_mem_checker.sv
/*
 * Reference checker for the Spectrum paging core.
 * Follows the bus to keep its own copy of the paging and FE state, and
 * on each check strobe compares the DUT outputs with the expected values.
 */
module zx_mem_checker (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         check_strobe,
	input  logic [159:0] test_name,
	input  logic [15:0]  addr,
	input  logic [7:0]   data_out,
	input  logic         n_mreq,
	input  logic         n_iorq,
	input  logic         n_rd,
	input  logic         n_wr,
	input  logic         n_m1,
	input  logic [2:0]   model,
	input  logic [11:0]  psg_left,
	input  logic [11:0]  psg_right,
	input  logic [24:0]  ram_addr,
	input  logic         ram_rd,
	input  logic         ram_we,
	input  logic [2:0]   border_color,
	input  logic         screen_page,
	input  logic [15:0]  audio_left,
	input  logic [15:0]  audio_right
);

	int         error_count = 0;
	int         test_count = 0;
	logic [5:0] r7ffd;
	logic [2:0] r1ffd;
	logic       r48;
	logic       rp3;
	logic [2:0] rborder;
	logic       rear;
	logic       rmic;

	// ==============================
	// Rule functions
	// ==============================

	function automatic logic [15:0] mix_rule(input logic [11:0] psg, input logic e,
			input logic m);
		logic [15:0] s;
		s = {psg, 4'b0000};
		if (e) s = s + 16'h1000;
		if (m) s = s + 16'h0800;
		return s;
	endfunction

	function automatic logic [15:0] comp_rule(input logic [15:0] s);
		int v;
		int mag;
		int r;
		v   = int'($signed(s));
		mag = (v < 0) ? -v : v;
		if (mag < 14043) r = mag * 2;
		else r = (mag - 14043) / 4 + 28086;
		if (v < 0) r = -r;
		return r[15:0];
	endfunction

	function automatic logic [24:0] addr_rule(input logic [15:0] a);
		logic [1:0] c;
		logic [3:0] rom;
		logic [6:0] page;
		int         bank;
		c = r1ffd[2:1];
		if (rp3) rom = {2'b10, r1ffd[2], r7ffd[4]};
		else rom = {r48, 2'b11, r48 | r7ffd[4]};
		if (r1ffd[0]) begin
			case (a[15:14])
				2'd0:    bank = (c != 0) ? 4 : 0;
				2'd1:    bank = ((c != 0) ? 4 : 0) + ((c == 3) ? 2 : 0) + 1;
				2'd2:    bank = ((c != 0) ? 4 : 0) + 2;
				default: bank = ((c == 1) ? 4 : 0) + 3;
			endcase
			page = 7'(bank);
		end else begin
			case (a[15:14])
				2'd0:    page = {3'd5, rom};
				2'd1:    page = 7'd5;
				2'd2:    page = 7'd2;
				default: page = {4'b0000, r7ffd[2:0]};
			endcase
		end
		return {4'b0000, page, a[13:0]};
	endfunction

	task automatic compare(input string what, input logic [31:0] exp,
			input logic [31:0] act, inout int fails);
		if (exp !== act) begin
			$display("Error: %0s %0s expected %h actual %h", test_name, what, exp, act);
			fails = fails + 1;
		end
	endtask

	// ==============================
	// Reset on the clock, check on strobe
	// ==============================

	always @(posedge clk_sys or posedge check_strobe) begin
		int   fails;
		logic lock;
		logic we_exp;
		if (check_strobe) begin
			fails = 0;
			lock  = r48 | r7ffd[5];
			if (!n_iorq && !n_wr && n_m1) begin
				if (!addr[15] && !addr[1] && (addr[14] || !rp3) && !lock) begin
					r7ffd = data_out[5:0];
				end
				if (rp3 && addr[15:12] == 4'b0001 && !addr[1] && !lock) begin
					r1ffd = data_out[2:0];
				end
				if (!addr[0]) begin
					rborder = data_out[2:0];
					rear    = data_out[4];
					rmic    = data_out[3];
				end
			end
			we_exp = !n_mreq && !n_wr && (r1ffd[0] || addr[15:14] != 2'd0);
			compare("ram_addr", 32'(addr_rule(addr)), 32'(ram_addr), fails);
			compare("ram_rd", 32'(!n_mreq && !n_rd), 32'(ram_rd), fails);
			compare("ram_we", 32'(we_exp), 32'(ram_we), fails);
			compare("screen_page", 32'(r7ffd[3]), 32'(screen_page), fails);
			compare("border_color", 32'(rborder), 32'(border_color), fails);
			compare("audio_left", 32'(comp_rule(mix_rule(psg_left, rear, rmic))),
				32'(audio_left), fails);
			compare("audio_right", 32'(comp_rule(mix_rule(psg_right, rear, rmic))),
				32'(audio_right), fails);
			test_count = test_count + 1;
			if (fails == 0) $display("ok   %0s", test_name);
			else error_count = error_count + 1;
		end else if (reset) begin
			r7ffd   = '0;
			r1ffd   = '0;
			r48     = (model == 3'd3);
			rp3     = (model == 3'd4);
			rborder = '0;
			rear    = 1'b0;
			rmic    = 1'b0;
		end
	end

endmodule

// File: logic/zx_mem_top.sv
/*
 * Top of the Spectrum paging core.
 * Connects the port decoder, the paging registers, the RAM address map
 * and the ULA sound output. The CPU bus comes in as raw Z80 strobes.
 */
module zx_mem_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  zx_mem_pkg::cpu_addr_t   addr,
	input  zx_mem_pkg::byte_t       data_out,
	input  logic                    n_mreq,
	input  logic                    n_iorq,
	input  logic                    n_rd,
	input  logic                    n_wr,
	input  logic                    n_m1,
	input  zx_mem_pkg::model_t      model,
	input  zx_mem_pkg::psg_sample_t psg_left,
	input  zx_mem_pkg::psg_sample_t psg_right,
	output zx_mem_pkg::ram_addr_t   ram_addr,
	output logic                    ram_rd,
	output logic                    ram_we,
	output logic [2:0]              border_color,
	output logic                    screen_page,
	output zx_mem_pkg::sample_t     audio_left,
	output zx_mem_pkg::sample_t     audio_right
);

	import zx_mem_pkg::*;

	logic      wr_7ffd;
	logic      wr_1ffd;
	logic      wr_fe;
	logic      plus3_mode;
	logic      page_lock;
	ram_bank_t ram_bank;
	rom_page_t rom_page;
	logic      special_mode;
	logic [1:0] special_cfg;

	io_port_decode io_port_decode_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.addr       (addr),
		.n_iorq     (n_iorq),
		.n_wr       (n_wr),
		.n_m1       (n_m1),
		.plus3_mode (plus3_mode),
		.page_lock  (page_lock),
		.wr_7ffd    (wr_7ffd),
		.wr_1ffd    (wr_1ffd),
		.wr_fe      (wr_fe)
	);

	paging_regs paging_regs_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.model        (model),
		.data_out     (data_out),
		.wr_7ffd      (wr_7ffd),
		.wr_1ffd      (wr_1ffd),
		.ram_bank     (ram_bank),
		.rom_page     (rom_page),
		.special_mode (special_mode),
		.special_cfg  (special_cfg),
		.screen_page  (screen_page),
		.plus3_mode   (plus3_mode),
		.page_lock    (page_lock)
	);

	ram_address_map ram_address_map_i (
		.addr         (addr),
		.n_mreq       (n_mreq),
		.n_rd         (n_rd),
		.n_wr         (n_wr),
		.ram_bank     (ram_bank),
		.rom_page     (rom_page),
		.special_mode (special_mode),
		.special_cfg  (special_cfg),
		.ram_addr     (ram_addr),
		.ram_rd       (ram_rd),
		.ram_we       (ram_we)
	);

	ula_sound_out ula_sound_out_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.wr_fe        (wr_fe),
		.data_out     (data_out),
		.psg_left     (psg_left),
		.psg_right    (psg_right),
		.border_color (border_color),
		.audio_left   (audio_left),
		.audio_right  (audio_right)
	);

endmodule

// File: logic/ula_sound_out.sv
/*
 * ULA output port and sound stage.
 * Latches border, ear and mic from a port FE write. Each channel adds the
 * PSG sample to the ear and mic levels in a first register stage, and a
 * second stage applies a soft-knee compressor to fit the 16-bit output.
 */
module ula_sound_out (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    wr_fe,
	input  zx_mem_pkg::byte_t       data_out,
	input  zx_mem_pkg::psg_sample_t psg_left,
	input  zx_mem_pkg::psg_sample_t psg_right,
	output logic [2:0]              border_color,
	output zx_mem_pkg::sample_t     audio_left,
	output zx_mem_pkg::sample_t     audio_right
);

	import zx_mem_pkg::*;

	logic    ear;
	logic    mic;
	sample_t pre_left;
	sample_t pre_right;

	// PSG level plus beeper weights, wraps like the real adder
	function automatic sample_t mix(input psg_sample_t psg, input logic ear_in,
			input logic mic_in);
		sample_t psg_part;
		sample_t ear_part;
		sample_t mic_part;
		psg_part = sample_t'(psg) << PSG_SHIFT;
		ear_part = sample_t'(ear_in) << EAR_BIT;
		mic_part = sample_t'(mic_in) << MIC_BIT;
		mix = psg_part + ear_part + mic_part;
	endfunction

	// Gain COMP_A below the knee, 1/COMP_F above, sign kept
	function automatic sample_t compress(input sample_t s);
		sample_t mag;
		sample_t res;
		mag = s[15] ? (~s + 16'd1) : s;
		if (mag < COMP_X) begin
			res = mag * COMP_A;
		end else begin
			res = ((mag - COMP_X) / COMP_F) + COMP_B;
		end
		compress = s[15] ? ~(res - 16'd1) : res;
	endfunction

	// ==============================
	// Port FE latch
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear          <= 1'b0;
			mic          <= 1'b0;
		end else if (wr_fe) begin
			border_color <= data_out[2:0];
			ear          <= data_out[4];
			mic          <= data_out[3];
		end
	end

	// ==============================
	// Mix and compress pipeline
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pre_left    <= '0;
			pre_right   <= '0;
			audio_left  <= '0;
			audio_right <= '0;
		end else begin
			pre_left    <= mix(psg_left, ear, mic);
			pre_right   <= mix(psg_right, ear, mic);
			audio_left  <= compress(pre_left);
			audio_right <= compress(pre_right);
		end
	end

endmodule

// File: logic/ram_address_map.sv
/*
 * CPU memory map into the external RAM.
 * Purely combinational. The 16K slot picked by A15..A14 selects a ROM
 * page or a RAM bank, and the low 14 bits pass straight through.
 * The +3 all-RAM modes replace the whole map with fixed bank sets.
 */
module ram_address_map (
	input  zx_mem_pkg::cpu_addr_t addr,
	input  logic                  n_mreq,
	input  logic                  n_rd,
	input  logic                  n_wr,
	input  zx_mem_pkg::ram_bank_t ram_bank,
	input  zx_mem_pkg::rom_page_t rom_page,
	input  logic                  special_mode,
	input  logic [1:0]            special_cfg,
	output zx_mem_pkg::ram_addr_t ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we
);

	import zx_mem_pkg::*;

	logic [1:0] slot;
	// Page field above the 14-bit offset
	logic [6:0] page_sel;
	ram_bank_t  special_bank;
	logic       cfg_any;
	logic       cfg_one;
	logic       cfg_three;

	assign slot      = addr[15:14];
	assign cfg_any   = |special_cfg;
	assign cfg_one   = (special_cfg == 2'd1);
	assign cfg_three = (special_cfg == 2'd3);

	// ==============================
	// Special all-RAM bank table
	// ==============================

	always_comb begin
		case (slot)
			2'd0:    special_bank = {cfg_any, 2'b00};
			2'd1:    special_bank = {cfg_any, cfg_three, 1'b1};
			2'd2:    special_bank = {cfg_any, 2'b10};
			default: special_bank = {cfg_one, 2'b11};
		endcase
	end

	// ==============================
	// Page select
	// ==============================

	always_comb begin
		if (special_mode) begin
			page_sel = {4'b0000, special_bank};
		end else begin
			case (slot)
				2'd0:    page_sel = {ROM_AREA_PREFIX, rom_page};
				2'd1:    page_sel = {4'b0000, SCREEN_BANK};
				2'd2:    page_sel = {4'b0000, MID_BANK};
				default: page_sel = {4'b0000, ram_bank};
			endcase
		end
	end

	assign ram_addr = {4'b0000, page_sel, addr[13:0]};

	// ROM slot is write protected unless all-RAM mode is on
	assign ram_rd = ~n_mreq & ~n_rd;
	assign ram_we = ~n_mreq & ~n_wr & (special_mode | (slot != 2'd0));

endmodule

// File: logic/paging_regs.sv
/*
 * Paging registers of the 128 and +3 machines.
 * Holds the 7FFD and 1FFD registers and the model flags latched during
 * reset, and derives the bank, ROM page, screen page, special mode and
 * lock state used by the address map and the port decoder.
 */
module paging_regs (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_mem_pkg::model_t   model,
	input  zx_mem_pkg::byte_t    data_out,
	input  logic                 wr_7ffd,
	input  logic                 wr_1ffd,
	output zx_mem_pkg::ram_bank_t ram_bank,
	output zx_mem_pkg::rom_page_t rom_page,
	output logic                 special_mode,
	output logic [1:0]           special_cfg,
	output logic                 screen_page,
	output logic                 plus3_mode,
	output logic                 page_lock
);

	import zx_mem_pkg::*;

	// Only the bits with a paging meaning are kept
	// 7FFD: [5] lock, [4] ROM select, [3] screen, [2:0] bank
	logic [5:0] page_7ffd;
	// 1FFD: [2:1] special config or ROM high bit, [0] special enable
	logic [2:0] page_1ffd;

	logic zx48;
	logic plus3;

	// ==============================
	// Register updates
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_7ffd <= '0;
			page_1ffd <= '0;
			zx48      <= (model == MODEL_48);
			plus3     <= (model == MODEL_PLUS3);
		end else begin
			if (wr_7ffd) begin
				page_7ffd <= data_out[5:0];
			end
			if (wr_1ffd) begin
				page_1ffd <= data_out[2:0];
			end
		end
	end

	// ==============================
	// Derived page state
	// ==============================

	// The 48 has no paging at all
	assign page_lock = zx48 | page_7ffd[5];

	always_comb begin
		if (plus3) begin
			rom_page = {2'b10, page_1ffd[2], page_7ffd[4]};
		end else begin
			rom_page = {zx48, 2'b11, zx48 | page_7ffd[4]};
		end
	end

	assign ram_bank     = page_7ffd[2:0];
	assign screen_page  = page_7ffd[3];
	assign special_mode = page_1ffd[0];
	assign special_cfg  = page_1ffd[2:1];
	assign plus3_mode   = plus3;

endmodule

// File: logic/io_port_decode.sv
/*
 * Z80 I/O write decoder for the paging and ULA ports.
 * Finds the first cycle of an I/O write and issues one-cycle select
 * pulses for 7FFD, 1FFD and FE, one clock after the write appears.
 * The paging selects are qualified by the +3 flag and the paging lock.
 */
module io_port_decode (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_mem_pkg::cpu_addr_t addr,
	input  logic                 n_iorq,
	input  logic                 n_wr,
	input  logic                 n_m1,
	input  logic                 plus3_mode,
	input  logic                 page_lock,
	output logic                 wr_7ffd,
	output logic                 wr_1ffd,
	output logic                 wr_fe
);

	logic io_wr;
	logic io_wr_prev;
	logic io_wr_start;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_fe;

	// I/O write outside of an interrupt acknowledge
	assign io_wr       = ~n_iorq & ~n_wr & n_m1;
	assign io_wr_start = io_wr & ~io_wr_prev;

	// ==============================
	// Port address decode
	// ==============================

	// 7FFD needs A14 high on the +3 so it does not alias 1FFD
	assign sel_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~plus3_mode) & ~page_lock;

	assign sel_1ffd = plus3_mode & (addr[15:12] == 4'b0001) & ~addr[1] & ~page_lock;

	// ULA answers on any even port
	assign sel_fe = ~addr[0];

	// ==============================
	// Edge detect and pulses
	// ==============================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_prev <= 1'b0;
			wr_7ffd    <= 1'b0;
			wr_1ffd    <= 1'b0;
			wr_fe      <= 1'b0;
		end else begin
			io_wr_prev <= io_wr;
			wr_7ffd    <= io_wr_start & sel_7ffd;
			wr_1ffd    <= io_wr_start & sel_1ffd;
			wr_fe      <= io_wr_start & sel_fe;
		end
	end

endmodule

// File: logic/zx_mem_pkg.sv
/*
 * Shared types and machine constants for the Spectrum memory paging core.
 * Modules use the scoped type names in their port lists and take the rest
 * through a wildcard import inside the module body.
 */
package zx_mem_pkg;

	// ==============================
	// Bus, address and sample types
	// ==============================

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [24:0] ram_addr_t;

	// ROM page inside the ROM area
	typedef logic [3:0]  rom_page_t;

	// 16K RAM bank number
	typedef logic [2:0]  ram_bank_t;

	typedef logic [2:0]  model_t;

	// Signed audio samples
	typedef logic [15:0] sample_t;
	typedef logic [11:0] psg_sample_t;

	// ==============================
	// Machine model codes
	// ==============================

	// Codes not listed here run as a 128
	localparam model_t MODEL_128   = 3'd0;
	localparam model_t MODEL_48    = 3'd3;
	localparam model_t MODEL_PLUS3 = 3'd4;

	// ==============================
	// Memory map
	// ==============================

	// ROM pages live above the RAM banks
	localparam logic [2:0] ROM_AREA_PREFIX = 3'd5;

	// Fixed banks seen at 4000h and 8000h
	localparam ram_bank_t SCREEN_BANK = 3'd5;
	localparam ram_bank_t MID_BANK    = 3'd2;

	// ==============================
	// Audio mix and compressor
	// ==============================

	localparam int EAR_BIT   = 12;
	localparam int MIC_BIT   = 11;
	localparam int PSG_SHIFT = 4;

	// Knee at COMP_X, gain COMP_A below it and 1/COMP_F above
	localparam sample_t COMP_F = 16'd4;
	localparam sample_t COMP_A = 16'd2;
	localparam sample_t COMP_X =
		sample_t'((32767 * (COMP_F - 1)) / (COMP_F * COMP_A - 1));
	localparam sample_t COMP_B = sample_t'(COMP_X * COMP_A);

endpackage
